//--- pf_params.svh
/*
 Widths, depths and opcode values for the packet filter
*/
`ifndef PF_PARAMS_SVH
`define PF_PARAMS_SVH

// Stream and buffer
`define PF_DATA_W     32
`define PF_KEEP_W     4
`define PF_MEM_WORDS  64    // 256 bytes of packet
`define PF_MEM_AW     6
`define PF_LEN_W      9     // Byte length up to 256
`define PF_DROP_W     16

// Instruction memory
`define PF_INST_DEPTH 16
`define PF_INST_AW    4
`define PF_INST_W     64

// Opcodes, classic BPF encodings with absolute addressing
`define PF_OP_LDB     16'h0030
`define PF_OP_LDH     16'h0028
`define PF_OP_ANDK    16'h0054
`define PF_OP_JEQ     16'h0015
`define PF_OP_JGT     16'h0025
`define PF_OP_RET     16'h0006

`endif

//--- pf_pkg.sv
/*
 Shared types: instruction word views, opcode enumeration, stream words
*/
`default_nettype none

`include "pf_params.svh"

package pf_pkg;

    typedef enum logic [15:0] {
        OP_LDB  = `PF_OP_LDB,
        OP_LDH  = `PF_OP_LDH,
        OP_ANDK = `PF_OP_ANDK,
        OP_JEQ  = `PF_OP_JEQ,
        OP_JGT  = `PF_OP_JGT,
        OP_RET  = `PF_OP_RET
    } bpf_op_e;

    // Jump view, branch offsets in the middle half-word
    typedef struct packed {
        logic [15:0] opcode;
        logic [7:0]  jt;
        logic [7:0]  jf;
        logic [31:0] k;
    } bpf_branch_t;

    // Load, AND and return view
    typedef struct packed {
        logic [15:0] opcode;
        logic [15:0] rsvd;
        logic [31:0] k;     // Offset, mask or verdict
    } bpf_plain_t;

    typedef union packed {
        bpf_branch_t br;
        bpf_plain_t  pl;
    } bpf_inst_u;

    typedef logic [`PF_DATA_W-1:0] data_word_t;
    typedef logic [`PF_KEEP_W-1:0] keep_t;
    typedef logic [`PF_LEN_W-1:0]  byte_len_t;
    typedef logic [`PF_DROP_W-1:0] drop_count_t;

endpackage

`default_nettype wire

//--- pf_snooper.sv
/*
 Snoop stream capture into the packet buffer
 Byte length tracking and dropped packet count
*/
`timescale 1ns/1ns
`default_nettype none

`include "pf_params.svh"

module pf_snooper (
    input  wire                      clk,
    input  wire                      reset,
    input  pf_pkg::data_word_t       sn_data,
    input  pf_pkg::keep_t            sn_keep,
    input  wire                      sn_valid,
    input  wire                      sn_ready,
    input  wire                      sn_last,
    input  wire                      buf_busy,
    output logic                     wr_en,
    output logic [`PF_MEM_AW-1:0]    wr_addr,
    output pf_pkg::data_word_t       wr_data,
    output logic                     pkt_done,
    output pf_pkg::byte_len_t        pkt_len,
    output logic                     capture_start,
    output pf_pkg::drop_count_t      drop_count
);

    logic                  beat;
    logic                  first;     // First beat of a packet
    logic                  cap_beat;  // Beat that goes into the buffer
    logic                  in_pkt;
    logic                  cap_q;     // Current packet is captured, not dropped
    logic [`PF_MEM_AW:0]   widx;      // Saturates at one past the last word
    logic [2:0]            keep_cnt;

    assign beat          = sn_valid && sn_ready;   // Passive, never stalls the stream
    assign first         = beat && !in_pkt;
    assign capture_start = first && !buf_busy;
    assign cap_beat      = capture_start || (beat && in_pkt && cap_q);
    assign keep_cnt      = 3'($countones(sn_keep));  // Keep is packed from bit 0

    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt     <= 1'b0;
            cap_q      <= 1'b0;
            widx       <= '0;
            wr_en      <= 1'b0;
            pkt_done   <= 1'b0;
            drop_count <= '0;
        end else begin
            if (beat)
                in_pkt <= !sn_last;
            if (first)
                cap_q <= !buf_busy;
            if (first && buf_busy)
                drop_count <= drop_count + 1;  // Once per dropped packet
            if (beat && sn_last)
                widx <= '0;
            else if (cap_beat && !widx[`PF_MEM_AW])
                widx <= widx + 1;
            wr_en    <= cap_beat && !widx[`PF_MEM_AW];  // Beyond 256 bytes is discarded
            pkt_done <= cap_beat && sn_last;
        end
    end

    // Write one cycle behind the beat
    always_ff @(posedge clk) begin
        wr_addr <= widx[`PF_MEM_AW-1:0];
        wr_data <= sn_data;
        if (cap_beat && sn_last) begin
            if (widx[`PF_MEM_AW])
                pkt_len <= pf_pkg::byte_len_t'(`PF_MEM_WORDS * 4);  // Truncated packet
            else
                pkt_len <= pf_pkg::byte_len_t'({widx[`PF_MEM_AW-1:0], 2'b00})
                         + pf_pkg::byte_len_t'(keep_cnt);
        end
    end

endmodule

`default_nettype wire

//--- pf_packet_mem.sv
/*
 Packet buffer, one write port and two registered read ports
*/
`timescale 1ns/1ns
`default_nettype none

`include "pf_params.svh"

module pf_packet_mem (
    input  wire                      clk,
    input  wire                      wr_en,
    input  wire [`PF_MEM_AW-1:0]     wr_addr,
    input  pf_pkg::data_word_t       wr_data,
    input  wire [`PF_MEM_AW-1:0]     rd_a_addr,
    input  wire [`PF_MEM_AW-1:0]     rd_b_addr,
    output pf_pkg::data_word_t       rd_a_data,
    output pf_pkg::data_word_t       rd_b_data
);

    // Byte 0 of the packet lands in bits 7:0 of word 0
    pf_pkg::data_word_t mem [`PF_MEM_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_a_data <= mem[rd_a_addr];   // Filter core side
        rd_b_data <= mem[rd_b_addr];   // Forwarder side
    end

endmodule

`default_nettype wire

//--- pf_decode.sv
/*
 Instruction memory with registered fetch and combinational decode
*/
`timescale 1ns/1ns
`default_nettype none

`include "pf_params.svh"

module pf_decode (
    input  wire                      clk,
    input  wire                      inst_wr_en,
    input  wire [`PF_INST_AW-1:0]    inst_wr_addr,
    input  pf_pkg::bpf_inst_u        inst_wr_data,
    input  wire                      fetch_en,
    input  wire [`PF_INST_AW-1:0]    fetch_addr,
    output pf_pkg::bpf_op_e          op,
    output logic [31:0]              k,
    output logic [7:0]               jt,
    output logic [7:0]               jf,
    output logic                     is_load,
    output logic                     is_jump,
    output logic                     is_ret
);

    pf_pkg::bpf_inst_u imem [`PF_INST_DEPTH];
    pf_pkg::bpf_inst_u inst_q;   // Held until the next fetch

    always_ff @(posedge clk) begin
        if (inst_wr_en)
            imem[inst_wr_addr] <= inst_wr_data;
        if (fetch_en)
            inst_q <= imem[fetch_addr];
    end

    always_comb begin
        op      = pf_pkg::bpf_op_e'(inst_q.pl.opcode);
        k       = inst_q.pl.k;
        jt      = '0;
        jf      = '0;
        is_load = 1'b0;
        is_jump = 1'b0;
        is_ret  = 1'b0;
        case (inst_q.pl.opcode)
            pf_pkg::OP_LDB, pf_pkg::OP_LDH: is_load = 1'b1;
            pf_pkg::OP_ANDK: ;                        // Mask in k
            pf_pkg::OP_JEQ, pf_pkg::OP_JGT: begin
                is_jump = 1'b1;
                jt      = inst_q.br.jt;
                jf      = inst_q.br.jf;
            end
            pf_pkg::OP_RET: is_ret = 1'b1;
            default: begin
                // Unknown code acts as a reject return
                op     = pf_pkg::OP_RET;
                k      = '0;
                is_ret = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- pf_execute.sv
/*
 Filter core FSM: program counter, accumulator, loads, jumps, verdict
*/
`timescale 1ns/1ns
`default_nettype none

`include "pf_params.svh"

module pf_execute (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      pkt_done,
    input  pf_pkg::byte_len_t        pkt_len,
    input  pf_pkg::bpf_op_e          op,
    input  wire [31:0]               k,
    input  wire [7:0]                jt,
    input  wire [7:0]                jf,
    input  wire                      is_load,
    input  wire                      is_jump,
    input  wire                      is_ret,
    input  pf_pkg::data_word_t       rd_a_data,
    output logic                     fetch_en,
    output logic [`PF_INST_AW-1:0]   fetch_addr,
    output logic [`PF_MEM_AW-1:0]    rd_a_addr,
    output logic                     verdict_valid,
    output logic                     verdict_accept
);

    typedef enum logic [2:0] {S_IDLE, S_FETCH, S_EXEC, S_LDWAIT, S_VERDICT} state_e;

    state_e                 state;
    logic [`PF_INST_AW-1:0] pc;
    logic [31:0]            acc;
    logic                   accept_q;
    logic                   split_q;    // High byte of a straddling half-word is in acc
    logic                   half;
    logic                   straddle;
    logic                   ld_oob;
    logic                   taken;
    logic [8:0]             next_pc;    // Wide enough for pc + 1 + 255
    logic                   pc_over;
    logic [7:0]             ld_b0;
    logic [7:0]             ld_b1;

    assign half     = (op == pf_pkg::OP_LDH);
    assign straddle = half && (k[1:0] == 2'd3);   // Half-word spans two buffer words
    assign ld_oob   = ({1'b0, k} + 33'(half)) >= 33'(pkt_len);
    assign ld_b0    = rd_a_data[{k[1:0], 3'b000} +: 8];
    assign ld_b1    = rd_a_data[{k[1:0] + 2'd1, 3'b000} +: 8];

    always_comb begin
        taken   = (op == pf_pkg::OP_JEQ) ? (acc == k) : (acc > k);   // Unsigned
        next_pc = 9'(pc) + 9'd1;
        if (is_jump)
            next_pc = next_pc + 9'(taken ? jt : jf);
        pc_over = next_pc >= 9'(`PF_INST_DEPTH);   // Ran off the program
    end

    assign fetch_en       = (state == S_FETCH);
    assign fetch_addr     = pc;
    assign rd_a_addr      = k[`PF_MEM_AW+1:2] + `PF_MEM_AW'(state == S_LDWAIT);
    assign verdict_valid  = (state == S_VERDICT);
    assign verdict_accept = accept_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= S_IDLE;
            pc       <= '0;
            acc      <= '0;
            accept_q <= 1'b0;
            split_q  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (pkt_done) begin
                    pc    <= '0;
                    acc   <= '0;
                    state <= S_FETCH;
                end
                S_FETCH: state <= S_EXEC;     // Instruction word valid next cycle
                S_EXEC: begin
                    if (is_ret) begin
                        accept_q <= (k != 32'd0);
                        state    <= S_VERDICT;
                    end else if (is_load) begin
                        accept_q <= 1'b0;
                        state    <= ld_oob ? S_VERDICT : S_LDWAIT;
                    end else begin
                        if (op == pf_pkg::OP_ANDK)
                            acc <= acc & k;
                        accept_q <= 1'b0;
                        pc       <= next_pc[`PF_INST_AW-1:0];
                        state    <= pc_over ? S_VERDICT : S_FETCH;
                    end
                end
                S_LDWAIT: begin
                    if (!half)
                        acc <= {24'd0, ld_b0};
                    else if (!straddle)
                        acc <= {16'd0, ld_b0, ld_b1};       // Big-endian
                    else if (!split_q)
                        acc <= {24'd0, rd_a_data[31:24]};   // Next word arrives next cycle
                    else
                        acc <= {16'd0, acc[7:0], rd_a_data[7:0]};
                    if (straddle && !split_q) begin
                        split_q <= 1'b1;
                    end else begin
                        split_q <= 1'b0;
                        pc      <= next_pc[`PF_INST_AW-1:0];
                        state   <= pc_over ? S_VERDICT : S_FETCH;
                    end
                end
                default: state <= S_IDLE;     // Verdict pulse lasts one cycle
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pf_forwarder.sv
/*
 Streams an accepted packet out of the buffer
 One read ahead plus a holding register for back-pressure
*/
`timescale 1ns/1ns
`default_nettype none

`include "pf_params.svh"

module pf_forwarder (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      verdict_valid,
    input  wire                      verdict_accept,
    input  pf_pkg::byte_len_t        pkt_len,
    input  pf_pkg::data_word_t       rd_b_data,
    input  wire                      out_ready,
    output logic [`PF_MEM_AW-1:0]    rd_b_addr,
    output pf_pkg::data_word_t       out_data,
    output pf_pkg::keep_t            out_keep,
    output logic                     out_last,
    output logic                     out_valid,
    output logic                     fwd_done
);

    logic                 start;
    logic                 active;
    pf_pkg::byte_len_t    len_q;
    pf_pkg::byte_len_t    len_eff;
    pf_pkg::byte_len_t    len_up;
    logic [`PF_MEM_AW:0]  nwords;
    logic [`PF_MEM_AW:0]  cnt;        // Words read so far
    pf_pkg::keep_t        last_keep;
    pf_pkg::keep_t        arr_keep;
    logic                 issue;
    logic                 rd_pend;    // rd_b_data holds a word this cycle
    logic                 pend_last;
    logic                 hold_valid;
    logic                 hold_last;
    pf_pkg::data_word_t   hold_data;
    logic                 out_load;

    assign start   = verdict_valid && verdict_accept;
    assign len_eff = start ? pkt_len : len_q;   // First read goes out in the verdict cycle
    assign len_up  = len_eff + 3;
    assign nwords  = len_up[`PF_LEN_W-1:2];

    always_comb begin
        case (len_q[1:0])
            2'd1:    last_keep = 4'b0001;
            2'd2:    last_keep = 4'b0011;
            2'd3:    last_keep = 4'b0111;
            default: last_keep = 4'b1111;
        endcase
    end

    // Never more words in flight than out and hold can absorb
    assign issue     = (start || active) && (cnt < nwords) && !hold_valid
                     && !(rd_pend && out_valid && !out_ready);
    assign rd_b_addr = cnt[`PF_MEM_AW-1:0];
    assign arr_keep  = pend_last ? last_keep : '1;
    assign out_load  = !out_valid || out_ready;
    assign fwd_done  = out_valid && out_ready && out_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            active     <= 1'b0;
            cnt        <= '0;
            rd_pend    <= 1'b0;
            hold_valid <= 1'b0;
            out_valid  <= 1'b0;
        end else begin
            if (start)
                active <= 1'b1;
            else if (fwd_done)
                active <= 1'b0;
            if (fwd_done)
                cnt <= '0;
            else if (issue)
                cnt <= cnt + 1;
            rd_pend <= issue;
            if (out_load) begin
                out_valid  <= hold_valid || rd_pend;
                hold_valid <= 1'b0;
            end else if (rd_pend) begin
                hold_valid <= 1'b1;    // Output stalled, park the word
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            len_q <= pkt_len;
        if (issue)
            pend_last <= (cnt + 1 == nwords);
        if (out_load) begin
            if (hold_valid) begin
                out_data <= hold_data;
                out_last <= hold_last;
                out_keep <= hold_last ? last_keep : '1;
            end else if (rd_pend) begin
                out_data <= rd_b_data;
                out_last <= pend_last;
                out_keep <= arr_keep;
            end
        end else if (rd_pend) begin
            hold_data <= rd_b_data;
            hold_last <= pend_last;
        end
    end

endmodule

`default_nettype wire

//--- pf_top.sv
/*
 Packet filter top: snooper, buffer, core and forwarder
 Owns the buffer-busy flag and the latched packet length
*/
`timescale 1ns/1ns
`default_nettype none

`include "pf_params.svh"

module pf_top (
    input  wire                      clk,
    input  wire                      reset,
    input  pf_pkg::data_word_t       sn_data,
    input  pf_pkg::keep_t            sn_keep,
    input  wire                      sn_valid,
    input  wire                      sn_ready,
    input  wire                      sn_last,
    input  wire                      out_ready,
    input  wire                      inst_wr_en,
    input  wire [`PF_INST_AW-1:0]    inst_wr_addr,
    input  pf_pkg::bpf_inst_u        inst_wr_data,
    output pf_pkg::data_word_t       out_data,
    output pf_pkg::keep_t            out_keep,
    output logic                     out_last,
    output logic                     out_valid,
    output pf_pkg::drop_count_t      drop_count
);

    logic                   wr_en;
    logic [`PF_MEM_AW-1:0]  wr_addr;
    pf_pkg::data_word_t     wr_data;
    logic                   pkt_done;
    pf_pkg::byte_len_t      pkt_len;
    pf_pkg::byte_len_t      len_q;
    logic                   capture_start;
    logic                   buf_busy;
    logic [`PF_MEM_AW-1:0]  rd_a_addr;
    logic [`PF_MEM_AW-1:0]  rd_b_addr;
    pf_pkg::data_word_t     rd_a_data;
    pf_pkg::data_word_t     rd_b_data;
    logic                   inst_we;
    logic                   fetch_en;
    logic [`PF_INST_AW-1:0] fetch_addr;
    pf_pkg::bpf_op_e        op;
    logic [31:0]            k;
    logic [7:0]             jt;
    logic [7:0]             jf;
    logic                   is_load;
    logic                   is_jump;
    logic                   is_ret;
    logic                   verdict_valid;
    logic                   verdict_accept;
    logic                   fwd_done;

    // Free buffer means the core is idle too
    assign inst_we = inst_wr_en && (reset || !buf_busy);

    always_ff @(posedge clk) begin
        if (reset)
            buf_busy <= 1'b0;
        else if (capture_start)
            buf_busy <= 1'b1;
        else if ((verdict_valid && !verdict_accept) || fwd_done)
            buf_busy <= 1'b0;   // Rejected or fully sent
    end

    always_ff @(posedge clk) begin
        if (pkt_done)
            len_q <= pkt_len;
    end

    pf_snooper i_snooper (
        .clk, .reset, .sn_data, .sn_keep, .sn_valid, .sn_ready, .sn_last, .buf_busy,
        .wr_en, .wr_addr, .wr_data, .pkt_done, .pkt_len, .capture_start, .drop_count
    );

    pf_packet_mem i_packet_mem (
        .clk, .wr_en, .wr_addr, .wr_data, .rd_a_addr, .rd_b_addr, .rd_a_data, .rd_b_data
    );

    pf_decode i_decode (
        .clk, .inst_wr_en(inst_we), .inst_wr_addr, .inst_wr_data, .fetch_en, .fetch_addr,
        .op, .k, .jt, .jf, .is_load, .is_jump, .is_ret
    );

    pf_execute i_execute (
        .clk, .reset, .pkt_done, .pkt_len(len_q), .op, .k, .jt, .jf, .is_load, .is_jump,
        .is_ret, .rd_a_data, .fetch_en, .fetch_addr, .rd_a_addr, .verdict_valid,
        .verdict_accept
    );

    pf_forwarder i_forwarder (
        .clk, .reset, .verdict_valid, .verdict_accept, .pkt_len(len_q), .rd_b_data,
        .out_ready, .rd_b_addr, .out_data, .out_keep, .out_last, .out_valid, .fwd_done
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
/*
 Testbench clock and synchronous reset generator
*/
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 100,   // ns
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        reset = 1'b0;   // Released with the other stimulus, off the edge
    end

endmodule

`default_nettype wire

//--- tb_pf_model.svh
/*
 Reference filter model, LCG, packet and program builders
*/
`ifndef TB_PF_MODEL_SVH
`define TB_PF_MODEL_SVH

pf_pkg::bpf_inst_u prog [`PF_INST_DEPTH];   // Copy of what is loaded into the DUT
logic [7:0]        pkt_bytes [256];          // Current packet, zero past its end
logic [31:0]       rng;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

function automatic logic [31:0] rand_next();
    rng = lcg_next(rng);
    return rng;
endfunction

// 1 to 64 bytes, upper bits of the LCG
function automatic int rand_len();
    logic [31:0] r;
    r = rand_next();
    return 1 + int'(r[29:24]);
endfunction

function automatic pf_pkg::bpf_inst_u encode(input logic [15:0] opc, input logic [7:0] jt,
                                             input logic [7:0] jf, input logic [31:0] k);
    pf_pkg::bpf_inst_u inst;
    inst = {opc, jt, jf, k};
    return inst;
endfunction

// Runs the program on pkt_bytes, returns 1 for accept
function automatic bit model_verdict(input int len);
    int          pc;
    int          nbytes;
    logic [15:0] op;
    logic [31:0] k;
    logic [31:0] acc;
    bit          taken;
    pc  = 0;
    acc = '0;
    while (pc < `PF_INST_DEPTH) begin
        op = prog[pc].pl.opcode;
        k  = prog[pc].pl.k;
        case (op)
            `PF_OP_LDB, `PF_OP_LDH: begin
                nbytes = (op == `PF_OP_LDH) ? 2 : 1;
                if (longint'(k) + nbytes > longint'(len))
                    return 1'b0;                            // Read past the packet end
                acc = (nbytes == 2) ? {16'd0, pkt_bytes[int'(k)], pkt_bytes[int'(k) + 1]}
                                    : {24'd0, pkt_bytes[int'(k)]};
                pc++;
            end
            `PF_OP_ANDK: begin
                acc = acc & k;
                pc++;
            end
            `PF_OP_JEQ, `PF_OP_JGT: begin
                if (op == `PF_OP_JEQ)
                    taken = (acc == k);
                else
                    taken = (acc > k);                      // Unsigned
                pc = pc + 1 + int'(taken ? prog[pc].br.jt : prog[pc].br.jf);
            end
            `PF_OP_RET: return k != 32'd0;
            default: return 1'b0;                           // Unknown opcode
        endcase
    end
    return 1'b0;   // Fell off the end
endfunction

task automatic build_packet(input int len, input bit hdr_match);
    logic [31:0] r;
    for (int i = 0; i < 256; i++) begin
        r = rand_next();
        pkt_bytes[i] = (i < len) ? r[23:16] : 8'h00;
    end
    if (hdr_match && len >= 14) begin
        pkt_bytes[12] = 8'h08;   // IPv4 ethertype
        pkt_bytes[13] = 8'h00;
    end
endtask

// Program 0 accepts everything, 1 filters on the ethertype, 2 works on byte fields
task automatic select_program(input int which);
    for (int i = 0; i < `PF_INST_DEPTH; i++)
        prog[i] = encode(`PF_OP_RET, 8'd0, 8'd0, 32'd0);
    case (which)
        0: prog[0] = encode(`PF_OP_RET, 8'd0, 8'd0, 32'd1);
        1: begin
            prog[0] = encode(`PF_OP_LDH, 8'd0, 8'd0, 32'd12);
            prog[1] = encode(`PF_OP_JEQ, 8'd0, 8'd1, 32'h0800);
            prog[2] = encode(`PF_OP_RET, 8'd0, 8'd0, 32'hffff);
        end
        default: begin
            prog[0] = encode(`PF_OP_LDB,  8'd0, 8'd0, 32'd5);
            prog[1] = encode(`PF_OP_ANDK, 8'd0, 8'd0, 32'hf0);
            prog[2] = encode(`PF_OP_JGT,  8'd0, 8'd2, 32'h70);
            prog[3] = encode(`PF_OP_LDB,  8'd0, 8'd0, 32'd40);    // Past the end when short
            prog[4] = encode(`PF_OP_RET,  8'd0, 8'd0, 32'd1);
            prog[5] = encode(`PF_OP_LDH,  8'd0, 8'd0, 32'd7);     // Spans two words
            prog[6] = encode(`PF_OP_JGT,  8'd0, 8'd1, 32'h8000);
            prog[7] = encode(`PF_OP_RET,  8'd0, 8'd0, 32'd1);
        end
    endcase
endtask

`endif

//--- tb_pf_top.sv
/*
 Packet filter testbench: stimulus, output monitor, compare tasks, timeout
*/
`timescale 1ns/1ns
`default_nettype none

`include "pf_params.svh"

module tb_pf_top;

    localparam int SEND_MAX = 16;                           // Beats of a 64-byte packet
    localparam int GAP      = 3 * `PF_INST_DEPTH + 70 + 4;  // Program, forwarding, done, verdict
    localparam int NUM_PKTS = 20 + 24 + 24 + 16 + 2 * 6;
    localparam int LIMIT    = NUM_PKTS * (SEND_MAX + GAP) + 6 * (`PF_INST_DEPTH + 2) + 3000;

    logic                   clk;
    logic                   reset;
    pf_pkg::data_word_t     sn_data;
    pf_pkg::keep_t          sn_keep;
    logic                   sn_valid;
    logic                   sn_ready;
    logic                   sn_last;
    logic                   out_ready;
    logic                   inst_wr_en;
    logic [`PF_INST_AW-1:0] inst_wr_addr;
    pf_pkg::bpf_inst_u      inst_wr_data;
    pf_pkg::data_word_t     out_data;
    pf_pkg::keep_t          out_keep;
    logic                   out_last;
    logic                   out_valid;
    pf_pkg::drop_count_t    drop_count;

    string                  test_name;
    bit                     bp_on;          // Random out_ready
    logic [31:0]            rdy_rng;
    int                     cycles = 0;
    pf_pkg::drop_count_t    exp_drops;
    pf_pkg::data_word_t     exp_data [$];   // One entry per expected output beat
    pf_pkg::keep_t          exp_keep [$];
    logic                   exp_last [$];
    pf_pkg::keep_t          mon_keep;

    `include "tb_pf_model.svh"

    tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(10)) i_clock_gen (.clk, .reset);

    pf_top i_pf_top (
        .clk, .reset, .sn_data, .sn_keep, .sn_valid, .sn_ready, .sn_last, .out_ready,
        .inst_wr_en, .inst_wr_addr, .inst_wr_data, .out_data, .out_keep, .out_last,
        .out_valid, .drop_count
    );

    function automatic pf_pkg::data_word_t pkt_word(input int w);
        return {pkt_bytes[4*w+3], pkt_bytes[4*w+2], pkt_bytes[4*w+1], pkt_bytes[4*w]};
    endfunction

    // One enable per byte that remains in the last beat
    function automatic pf_pkg::keep_t len_keep(input int len);
        pf_pkg::keep_t keep;
        int            nbytes;
        nbytes = len - 4 * ((len - 1) / 4);   // 1 to 4
        for (int i = 0; i < 4; i++)
            keep[i] = (i < nbytes);
        return keep;
    endfunction

    function automatic pf_pkg::data_word_t keep_mask(input pf_pkg::keep_t keep);
        pf_pkg::data_word_t m;
        for (int i = 0; i < 4; i++)
            m[8*i +: 8] = {8{keep[i]}};
        return m;
    endfunction

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string what, input pf_pkg::data_word_t exp,
                              input pf_pkg::data_word_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %08h actual %08h", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_keep(input string what, input pf_pkg::keep_t exp,
                              input pf_pkg::keep_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %04b actual %04b", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_drops(input string what, input pf_pkg::drop_count_t exp,
                               input pf_pkg::drop_count_t act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic write_program();
        for (int i = 0; i < `PF_INST_DEPTH; i++) begin
            @(posedge clk);
            #10;
            inst_wr_en   = 1'b1;
            inst_wr_addr = i[`PF_INST_AW-1:0];
            inst_wr_data = prog[i];
        end
        @(posedge clk);
        #10;
        inst_wr_en = 1'b0;
    endtask

    task automatic push_expected(input int len);
        int nwords;
        nwords = (len + 3) / 4;
        for (int w = 0; w < nwords; w++) begin
            exp_data.push_back(pkt_word(w));
            exp_keep.push_back((w == nwords - 1) ? len_keep(len) : 4'hf);
            exp_last.push_back(w == nwords - 1);
        end
    endtask

    // Last beat stays on the bus so the next packet can follow at once
    task automatic send_packet(input int len);
        int nwords;
        nwords = (len + 3) / 4;
        for (int w = 0; w < nwords; w++) begin
            @(posedge clk);
            #10;
            sn_valid = 1'b1;
            sn_ready = 1'b1;
            sn_data  = pkt_word(w);
            sn_keep  = (w == nwords - 1) ? len_keep(len) : 4'hf;
            sn_last  = (w == nwords - 1);
        end
    endtask

    task automatic end_packet();
        @(posedge clk);
        #10;
        sn_valid = 1'b0;
        sn_ready = 1'b0;
        sn_last  = 1'b0;
        repeat (GAP) @(posedge clk);
        while (exp_data.size() != 0)
            @(posedge clk);        // Still stalled by out_ready
        repeat (2) @(posedge clk);
        #10;
    endtask

    task automatic run_packet(input int len, input bit hdr_match);
        build_packet(len, hdr_match);
        if (model_verdict(len))
            push_expected(len);
        send_packet(len);
        end_packet();
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            stop_on_error();
        end
    end

    // Random output back-pressure from a second LCG stream
    initial begin
        out_ready = 1'b1;
        rdy_rng   = lcg_next(32'hda5dc43c);
        forever begin
            @(posedge clk);
            #10;
            rdy_rng   = lcg_next(rdy_rng);
            out_ready = bp_on ? rdy_rng[26] : 1'b1;
        end
    end

    // Sampled mid-cycle ahead of the transfer edge
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (exp_data.size() == 0) begin
                $display("%s: DUT sent a beat while no accepted packet was pending", test_name);
                stop_on_error();
            end else begin
                mon_keep = exp_keep.pop_front();
                check_word("data", exp_data.pop_front(), out_data & keep_mask(mon_keep));
                check_keep("keep", mon_keep, out_keep);
                check_flag("last", exp_last.pop_front(), out_last);
            end
        end
    end

    initial begin
        int len;
        sn_data      = '0;
        sn_keep      = '0;
        sn_valid     = 1'b0;
        sn_ready     = 1'b0;
        sn_last      = 1'b0;
        inst_wr_en   = 1'b0;
        inst_wr_addr = '0;
        inst_wr_data = '0;
        bp_on        = 1'b0;
        exp_drops    = '0;
        rng          = 32'hda5dc43c;
        test_name    = "reset";
        select_program(0);
        write_program();           // Starts under reset
        while (reset)
            @(posedge clk);
        #10;
        check_flag("out_valid", 1'b0, out_valid);
        check_drops("drop_count", exp_drops, drop_count);

        test_name = "accept_all";
        for (int i = 0; i < 20; i++)
            run_packet(rand_len(), 1'b0);

        test_name = "header_filter";
        select_program(1);
        write_program();
        for (int i = 0; i < 24; i++)
            run_packet(rand_len(), (i % 3) != 2);

        test_name = "byte_fields";
        select_program(2);
        write_program();
        for (int i = 0; i < 24; i++)
            run_packet(rand_len(), 1'b0);

        test_name = "back_pressure";
        select_program(0);
        write_program();
        bp_on = 1'b1;
        for (int i = 0; i < 16; i++)
            run_packet(rand_len(), 1'b0);
        bp_on = 1'b0;
        check_drops("drop_count", exp_drops, drop_count);

        test_name = "drops";
        for (int i = 0; i < 6; i++) begin
            len = rand_len();
            build_packet(len, 1'b0);
            if (model_verdict(len))
                push_expected(len);
            send_packet(len);
            len = rand_len();
            build_packet(len, 1'b0);
            send_packet(len);      // Buffer still busy with the first one
            exp_drops = exp_drops + 1'b1;
            end_packet();
            check_drops("drop_count", exp_drops, drop_count);
        end

        test_name = "end";
        if (exp_data.size() != 0) begin
            $display("%0d expected output beats never came out", exp_data.size());
            stop_on_error();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
pf_pkg.sv
pf_snooper.sv
pf_packet_mem.sv
pf_decode.sv
pf_execute.sv
pf_forwarder.sv
pf_top.sv
tb_clock_gen.sv
tb_pf_top.sv

//--- run.sh
#!/bin/sh
# Build and run the packet filter testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sources.f --top-module tb_pf_top -o sim_pf
./obj_dir/sim_pf > sim.log 2>&1 || true
cat sim.log
if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    exit 1
fi
exit 0
